/* Bender.yml */
package:
  name: act_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/actCfgPkg.sv
      - design/actStreamPkg.sv
      - design/actCfgRegs.sv
      - design/actLoopCtrl.sv
      - design/actFetchCredit.sv
      - design/actCtrlTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/act_ctrl_props.sv
      - testbench/actCtrlTb.sv

/* design/actCfgPkg.sv */
`include "act_config.svh"

package actCfgPkg;

    // Register address, selects how the write word is decoded
    typedef logic [0:0] cfgAddr_t;

    localparam cfgAddr_t CFG_ADDR_SHAPE = 1'b0;
    localparam cfgAddr_t CFG_ADDR_LOOP = 1'b1;

    localparam int CFG_WORD_W = 32;

    // Shape of one patch
    typedef struct packed {
        logic [`ROW_W-1:0] lenRow;   // Words per row minus one
        logic [`BLK_W-1:0] numBlk;   // Blocks per frame minus one
        logic [`FRM_W-1:0] numFrm;   // Frames per patch minus one
    } cfgShape_t;

    // Pass loops and their order
    typedef struct packed {
        logic [`PAT_W-1:0] numPat;
        logic [`GRP_W-1:0] numFtrGrp;
        logic patchFirst;            // 1 means patch index is the inner loop
    } cfgLoop_t;

    localparam int SHAPE_PAD_W = CFG_WORD_W - $bits(cfgShape_t);
    localparam int LOOP_PAD_W = CFG_WORD_W - $bits(cfgLoop_t);

    // Fields sit in the low bits, upper bits are don't care
    typedef union packed {
        struct packed {
            logic [SHAPE_PAD_W-1:0] pad;
            cfgShape_t f;
        } shape;
        struct packed {
            logic [LOOP_PAD_W-1:0] pad;
            cfgLoop_t f;
        } loops;
    } cfgWord_u;

endpackage

/* design/actCfgRegs.sv */
`include "act_config.svh"

module actCfgRegs
    import actCfgPkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfgWrEn,
    input  cfgAddr_t            cfgAddr,
    input  cfgWord_u            cfgData,
    input  logic                start,
    input  logic                busy,
    output logic [`ROW_W-1:0]   lenRow,
    output logic [`BLK_W-1:0]   numBlk,
    output logic [`FRM_W-1:0]   numFrm,
    output logic [`PAT_W-1:0]   numPat,
    output logic [`GRP_W-1:0]   numFtrGrp,
    output logic                patchFirst,
    output logic [`WORDS_W-1:0] layerWords
);

    // Loop extents widened to the word count
    logic [`WORDS_W-1:0] extRow;
    logic [`WORDS_W-1:0] extBlk;
    logic [`WORDS_W-1:0] extFrm;
    logic [`WORDS_W-1:0] extPat;
    logic [`WORDS_W-1:0] extGrp;

    assign extRow = `WORDS_W'(lenRow) + 1'b1;
    assign extBlk = `WORDS_W'(numBlk) + 1'b1;
    assign extFrm = `WORDS_W'(numFrm) + 1'b1;
    assign extPat = `WORDS_W'(numPat) + 1'b1;
    assign extGrp = `WORDS_W'(numFtrGrp) + 1'b1;

    // Config write port, locked while a layer runs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lenRow <= '0;
            numBlk <= '0;
            numFrm <= '0;
            numPat <= '0;
            numFtrGrp <= '0;
            patchFirst <= 1'b0;
        end else if (cfgWrEn && !busy) begin
            case (cfgAddr)
                CFG_ADDR_SHAPE: begin
                    lenRow <= cfgData.shape.f.lenRow;
                    numBlk <= cfgData.shape.f.numBlk;
                    numFrm <= cfgData.shape.f.numFrm;
                end
                default: begin
                    numPat <= cfgData.loops.f.numPat;
                    numFtrGrp <= cfgData.loops.f.numFtrGrp;
                    patchFirst <= cfgData.loops.f.patchFirst;
                end
            endcase
        end
    end

    // Square block, so the row extent counts twice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layerWords <= '0;
        end else if (start && !busy) begin
            layerWords <= extRow * extRow * extBlk * extFrm * extPat * extGrp;
        end
    end

endmodule

/* design/actCtrlTop.sv */
`include "act_config.svh"

module actCtrlTop
    import actCfgPkg::*;
    import actStreamPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfgWrEn,
    input  cfgAddr_t cfgAddr,
    input  cfgWord_u cfgData,
    input  logic     start,
    output logic     busy,
    output logic     actReq,
    input  logic     actValid,
    input  actData_t actData,
    output logic     outValid,
    output actData_t outData,
    output logic     outFrtRow,
    output logic     outLstRow,
    output logic     outLstBlk,
    output logic     outFrtBlk,
    output logic     outEvenFrm,
    output logic     outValPsum,
    output logic     outValCol,
    output logic     outNextPatch,
    output logic     outNextFtrGrp,
    output logic     layerDone,
    input  logic     outCredit
);

    // ======================================================================
    // Config to loop control and fetch
    // ======================================================================

    logic [`ROW_W-1:0]   lenRow;
    logic [`BLK_W-1:0]   numBlk;
    logic [`FRM_W-1:0]   numFrm;
    logic [`PAT_W-1:0]   numPat;
    logic [`GRP_W-1:0]   numFtrGrp;
    logic                patchFirst;
    logic [`WORDS_W-1:0] layerWords;

    // Markers of the word now on actData
    logic frtActRow, lstActRow, lstActBlk, frtBlk, evenFrm;
    logic valPsum, valCol, nextPatch, nextFtrGrp, lstActLay;

    actCfgRegs cfgRegs_i (
        .clk(clk), .rst_n(rst_n), .cfgWrEn(cfgWrEn), .cfgAddr(cfgAddr),
        .cfgData(cfgData), .start(start), .busy(busy),
        .lenRow(lenRow), .numBlk(numBlk), .numFrm(numFrm), .numPat(numPat),
        .numFtrGrp(numFtrGrp), .patchFirst(patchFirst), .layerWords(layerWords)
    );

    // A start during a layer must not disturb the counters
    actLoopCtrl loopCtrl_i (
        .clk(clk), .rst_n(rst_n), .start(start && !busy), .getAct(actValid),
        .lenRow(lenRow), .numBlk(numBlk), .numFrm(numFrm), .numPat(numPat),
        .numFtrGrp(numFtrGrp), .patchFirst(patchFirst),
        .frtActRow(frtActRow), .lstActRow(lstActRow), .lstActBlk(lstActBlk),
        .frtBlk(frtBlk), .evenFrm(evenFrm), .valPsum(valPsum), .valCol(valCol),
        .nextPatch(nextPatch), .nextFtrGrp(nextFtrGrp), .lstActLay(lstActLay)
    );

    actFetchCredit fetch_i (
        .clk(clk), .rst_n(rst_n), .start(start), .layerWords(layerWords),
        .actValid(actValid), .actData(actData), .outCredit(outCredit),
        .frtActRow(frtActRow), .lstActRow(lstActRow), .lstActBlk(lstActBlk),
        .frtBlk(frtBlk), .evenFrm(evenFrm), .valPsum(valPsum), .valCol(valCol),
        .nextPatch(nextPatch), .nextFtrGrp(nextFtrGrp), .lstActLay(lstActLay),
        .busy(busy), .actReq(actReq), .outValid(outValid), .outData(outData),
        .outFrtRow(outFrtRow), .outLstRow(outLstRow), .outLstBlk(outLstBlk),
        .outFrtBlk(outFrtBlk), .outEvenFrm(outEvenFrm), .outValPsum(outValPsum),
        .outValCol(outValCol), .outNextPatch(outNextPatch),
        .outNextFtrGrp(outNextFtrGrp), .layerDone(layerDone)
    );

endmodule

/* design/actFetchCredit.sv */
`include "act_config.svh"

module actFetchCredit
    import actStreamPkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [`WORDS_W-1:0] layerWords,
    input  logic                actValid,
    input  actData_t            actData,
    input  logic                outCredit,
    input  logic                frtActRow,
    input  logic                lstActRow,
    input  logic                lstActBlk,
    input  logic                frtBlk,
    input  logic                evenFrm,
    input  logic                valPsum,
    input  logic                valCol,
    input  logic                nextPatch,
    input  logic                nextFtrGrp,
    input  logic                lstActLay,
    output logic                busy,
    output logic                actReq,
    output logic                outValid,
    output actData_t            outData,
    output logic                outFrtRow,
    output logic                outLstRow,
    output logic                outLstBlk,
    output logic                outFrtBlk,
    output logic                outEvenFrm,
    output logic                outValPsum,
    output logic                outValCol,
    output logic                outNextPatch,
    output logic                outNextFtrGrp,
    output logic                layerDone
);

    logic [`CRD_W-1:0]   crdCnt;    // Free slots on the PE array side
    logic [`WORDS_W-1:0] reqCnt;    // Requests issued in this layer
    logic                startAcc;

    assign startAcc = start && !busy;

    // One request per cycle while credits and words remain
    assign actReq = busy && (crdCnt != '0) && (reqCnt != layerWords);

    // ======================================================================
    // Layer and credit bookkeeping
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            reqCnt <= '0;
        end else if (startAcc) begin
            busy <= 1'b1;
            reqCnt <= '0;
        end else begin
            if (layerDone) begin
                busy <= 1'b0;       // Falls right after the last word
            end
            if (actReq) begin
                reqCnt <= reqCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crdCnt <= `CRD_W'(`ACT_CREDITS);
        end else begin
            case ({actReq, outCredit})
                2'b10: crdCnt <= crdCnt - 1'b1;
                2'b01: crdCnt <= crdCnt + 1'b1;
                default: crdCnt <= crdCnt;   // Spend and return cancel
            endcase
        end
    end

    // ======================================================================
    // Output stage, one cycle behind the memory return
    // ======================================================================

    always_ff @(posedge clk) begin
        outData <= actData;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid <= 1'b0;
            outFrtRow <= 1'b0;
            outLstRow <= 1'b0;
            outLstBlk <= 1'b0;
            outFrtBlk <= 1'b0;
            outEvenFrm <= 1'b0;
            outValPsum <= 1'b0;
            outValCol <= 1'b0;
            outNextPatch <= 1'b0;
            outNextFtrGrp <= 1'b0;
            layerDone <= 1'b0;
        end else begin
            outValid <= actValid;
            outFrtRow <= frtActRow;
            outLstRow <= lstActRow;
            outLstBlk <= lstActBlk;
            outFrtBlk <= frtBlk;
            outEvenFrm <= evenFrm;
            outValPsum <= valPsum;
            outValCol <= valCol;
            // Pass pulses only with a real word
            outNextPatch <= actValid && nextPatch;
            outNextFtrGrp <= actValid && nextFtrGrp;
            layerDone <= actValid && lstActLay;
        end
    end

endmodule

/* design/actLoopCtrl.sv */
`include "act_config.svh"

module actLoopCtrl
    import actStreamPkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              getAct,     // One word returned from memory
    input  logic [`ROW_W-1:0] lenRow,
    input  logic [`BLK_W-1:0] numBlk,
    input  logic [`FRM_W-1:0] numFrm,
    input  logic [`PAT_W-1:0] numPat,
    input  logic [`GRP_W-1:0] numFtrGrp,
    input  logic              patchFirst,
    output logic              frtActRow,
    output logic              lstActRow,
    output logic              lstActBlk,
    output logic              frtBlk,
    output logic              evenFrm,
    output logic              valPsum,
    output logic              valCol,
    output logic              nextPatch,
    output logic              nextFtrGrp,
    output logic              lstActLay
);

    // ======================================================================
    // Counter state
    // ======================================================================

    logic [`ROW_W-1:0] cntCol;
    logic [`ROW_W-1:0] cntRow;
    logic [`BLK_W-1:0] cntBlk;
    logic [`FRM_W-1:0] cntFrm;
    logic [`PAT_W-1:0] cntPat;
    logic [`GRP_W-1:0] cntGrp;

    logic       lstActFrm;
    logic       lstActPass;
    logic       lstPat;
    logic       lstGrp;
    logic       patStep;        // Patch index moves at the end of this pass
    logic       grpStep;        // Filter group index moves at the end of this pass
    loopOrder_e order;

    // ======================================================================
    // Word position markers
    // ======================================================================

    assign frtActRow = (cntCol == '0);
    assign lstActRow = (cntCol == lenRow);
    assign lstActBlk = (cntRow == lenRow) && lstActRow;
    assign lstActFrm = (cntBlk == numBlk) && lstActBlk;
    assign lstActPass = (cntFrm == numFrm) && lstActFrm;

    assign frtBlk = (cntBlk == '0);
    assign evenFrm = ~cntFrm[0];
    assign valCol = (cntCol >= `ROW_W'd2);   // First two columns only prime the window
    assign valPsum = (cntRow >= `ROW_W'd2);

    // ======================================================================
    // Pass ordering
    // ======================================================================

    assign order = loopOrder_e'(patchFirst);
    assign lstPat = (cntPat == numPat);
    assign lstGrp = (cntGrp == numFtrGrp);

    assign patStep = (order == PATCH_INNER) ? 1'b1 : lstGrp;
    assign grpStep = (order == FTRGRP_INNER) ? 1'b1 : lstPat;

    assign lstActLay = lstActPass && lstPat && lstGrp;

    // A single-valued index never changes, and the last pass has no successor
    assign nextPatch = lstActPass && patStep && (numPat != '0) && !lstActLay;
    assign nextFtrGrp = lstActPass && grpStep && (numFtrGrp != '0) && !lstActLay;

    // ======================================================================
    // Nested counters
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cntCol <= '0;
            cntRow <= '0;
        end else if (start) begin
            cntCol <= '0;
            cntRow <= '0;
        end else if (getAct) begin
            cntCol <= lstActRow ? '0 : cntCol + 1'b1;
            if (lstActBlk) begin
                cntRow <= '0;
            end else if (lstActRow) begin
                cntRow <= cntRow + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cntBlk <= '0;
            cntFrm <= '0;
        end else if (start) begin
            cntBlk <= '0;
            cntFrm <= '0;
        end else if (getAct) begin
            if (lstActFrm) begin
                cntBlk <= '0;
            end else if (lstActBlk) begin
                cntBlk <= cntBlk + 1'b1;
            end
            if (lstActPass) begin
                cntFrm <= '0;
            end else if (lstActFrm) begin
                cntFrm <= cntFrm + 1'b1;
            end
        end
    end

    // Both pass indices wrap together on the last word of the layer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cntPat <= '0;
            cntGrp <= '0;
        end else if (start) begin
            cntPat <= '0;
            cntGrp <= '0;
        end else if (getAct && lstActPass) begin
            if (patStep) begin
                cntPat <= lstPat ? '0 : cntPat + 1'b1;
            end
            if (grpStep) begin
                cntGrp <= lstGrp ? '0 : cntGrp + 1'b1;
            end
        end
    end

endmodule

/* design/actStreamPkg.sv */
`include "act_config.svh"

package actStreamPkg;

    // One activation word as it comes from memory
    typedef logic [`ACT_DATA_W-1:0] actData_t;

    // Which pass index moves fastest
    typedef enum logic {
        FTRGRP_INNER = 1'b0,   // All filter groups for one patch, then next patch
        PATCH_INNER = 1'b1     // All patches for one filter group, then next group
    } loopOrder_e;

endpackage

/* design/act_config.svh */
`ifndef ACT_CONFIG_SVH
`define ACT_CONFIG_SVH

//==========================================================================
// Datapath widths
//==========================================================================

`define ACT_DATA_W 16   // One activation word

//==========================================================================
// Loop shape field widths, every count stored minus one
//==========================================================================

`define ROW_W 5         // Row length, also rows per block
`define BLK_W 4         // Blocks per frame
`define FRM_W 4         // Frames per patch
`define PAT_W 4         // Patches per layer
`define GRP_W 4         // Filter groups per layer

// Total words of one layer
`define WORDS_W 24

//==========================================================================
// Flow control
//==========================================================================

`define ACT_CREDITS 4   // Slots on the PE array side
`define CRD_W 3         // Must hold 0 .. ACT_CREDITS

`endif

/* filelist.f */
+incdir+design
design/actCfgPkg.sv
design/actStreamPkg.sv
design/actCfgRegs.sv
design/actLoopCtrl.sv
design/actFetchCredit.sv
design/actCtrlTop.sv
testbench/act_ctrl_props.sv
testbench/actCtrlTb.sv

/* testbench/actCtrlTb.sv */
`include "act_config.svh"

module actCtrlTb
    import actCfgPkg::*;
    import actStreamPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic     clk, rst_n, cfgWrEn, start, busy, actReq, actValid, outValid, outCredit;
    logic     outFrtRow, outLstRow, outLstBlk, outFrtBlk, outEvenFrm, outValPsum, outValCol;
    logic     outNextPatch, outNextFtrGrp, layerDone;
    cfgAddr_t cfgAddr;
    cfgWord_u cfgData;
    actData_t actData;
    actData_t outData;

    integer   seed;
    int       tab[32][11];           // One row per case as laid out in the data file
    int       numCases;
    int       cycleLimit;
    int       cycle, checkCnt, valueErrs, otherErrs;
    int       caseIdx, wordIdx, reqIdx, npCnt, ngCnt, busyCycles, outstanding;
    int       extRow, extBlk, extFrm, extPat, extGrp, passWords, wordsModel;
    int       maxLat, maxDelay;
    bit       patInner, prevDone, doneSeen;
    cfgWord_u shapeWord, loopWord;
    int       memQ[$];               // Request indices waiting in memory
    int       readyQ[$];             // Cycle at which each can return
    int       crdQ[$];               // Cycle at which each credit goes back

    actCtrlTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    initial begin
        wait (cycleLimit > 0);
        repeat (cycleLimit) @(posedge clk);
        otherErrs++;
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        reportCounts();
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCnt++;
        if (got !== exp) begin
            valueErrs++;
            $display("Error: %s is 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle);
        end
    endtask

    task automatic reportCounts();
        $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
                 checkCnt, valueErrs, otherErrs, dut_i.fetch_i.props_i.failCnt);
    endtask

    // Pass index to patch and filter group with the inner loop first
    function automatic int patOf(input int pass);
        return patInner ? pass % extPat : pass / extGrp;
    endfunction

    function automatic int grpOf(input int pass);
        return patInner ? pass / extPat : pass % extGrp;
    endfunction

    // ======================================================================
    // Reference model for one output word
    // ======================================================================

    task automatic checkWord();
        int  col, row, blk, frm, pass;
        bit  lastOfPass, morePasses;
        if (wordIdx >= wordsModel) begin
            otherErrs++;
            $display("Received more words than the layer holds (cycle %0d)", cycle);
        end else begin
            col = wordIdx % extRow;
            row = (wordIdx / extRow) % extRow;       // Square block
            blk = (wordIdx / (extRow * extRow)) % extBlk;
            frm = (wordIdx / (extRow * extRow * extBlk)) % extFrm;
            pass = wordIdx / passWords;
            lastOfPass = (wordIdx % passWords) == passWords - 1;
            morePasses = pass < extPat * extGrp - 1;
            check("outData", outData, 16'(wordIdx + 'h5a00));
            check("outFrtRow", outFrtRow, col == 0);
            check("outLstRow", outLstRow, col == extRow - 1);
            check("outLstBlk", outLstBlk, col == extRow - 1 && row == extRow - 1);
            check("outFrtBlk", outFrtBlk, blk == 0);
            check("outEvenFrm", outEvenFrm, frm % 2 == 0);
            check("outValCol", outValCol, col >= 2);
            check("outValPsum", outValPsum, row >= 2);
            check("outNextPatch", outNextPatch,
                  lastOfPass && morePasses && patOf(pass + 1) != patOf(pass));
            check("outNextFtrGrp", outNextFtrGrp,
                  lastOfPass && morePasses && grpOf(pass + 1) != grpOf(pass));
            check("layerDone", layerDone, wordIdx == wordsModel - 1);
        end
        npCnt += outNextPatch;
        ngCnt += outNextFtrGrp;
        wordIdx++;
    endtask

    // ======================================================================
    // One clock cycle sampled on the falling edge before driving
    // ======================================================================

    task automatic stepCycle();
        @(negedge clk);
        if (outValid) begin
            checkWord();
        end else begin
            check("layerDone", layerDone, 0);
            check("outNextPatch", outNextPatch, 0);
            check("outNextFtrGrp", outNextFtrGrp, 0);
        end
        if (prevDone) begin
            check("busy", busy, 0);   // Cycle after the last word
        end
        prevDone = outValid && layerDone;
        doneSeen = doneSeen || prevDone;
        if (caseIdx == 0 && busy && busyCycles < `ACT_CREDITS) begin
            check("actReq", actReq, 1);   // Full credit right after reset
        end
        if (actReq) begin
            memQ.push_back(reqIdx);
            readyQ.push_back(cycle + 1 + $unsigned($random(seed)) % maxLat);
            reqIdx++;
            outstanding++;
        end
        if (outstanding > `ACT_CREDITS) begin
            otherErrs++;
            $display("More requests in flight than the credits allow (cycle %0d)", cycle);
        end
        if (outValid) begin
            crdQ.push_back(cycle + $unsigned($random(seed)) % (maxDelay + 1));
        end
        start = 1'b0;
        cfgWrEn = 1'b0;
        if (busy && busyCycles == 2) begin
            start = 1'b1;               // Restart attempt mid-layer
            cfgWrEn = 1'b1;
            cfgAddr = CFG_ADDR_SHAPE;
            cfgData = ~shapeWord;
        end else if (busy && busyCycles == 3) begin
            cfgWrEn = 1'b1;
            cfgAddr = CFG_ADDR_LOOP;
            cfgData = ~loopWord;
        end
        if (busy) begin
            busyCycles++;
        end
        // Memory returns in request order
        if (memQ.size() > 0 && readyQ[0] <= cycle) begin
            actValid = 1'b1;
            actData = actData_t'(memQ.pop_front() + 'h5a00);
            void'(readyQ.pop_front());
        end else begin
            actValid = 1'b0;
        end
        if (crdQ.size() > 0 && crdQ[0] <= cycle) begin
            outCredit = 1'b1;
            void'(crdQ.pop_front());
            outstanding--;
        end else begin
            outCredit = 1'b0;
        end
        cycle++;
    endtask

    task automatic readCases();
        int    fd;
        int    n;
        int    v[11];
        string line;
        numCases = 0;
        fd = $fopen("testbench/act_ctrl_input.txt", "r");
        if (fd == 0) begin
            otherErrs++;
            $display("Cannot open testbench/act_ctrl_input.txt");
            return;
        end
        while (!$feof(fd) && numCases < 32) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
                            v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
                if (n == 11) begin
                    tab[numCases] = v;
                    numCases++;
                end else begin
                    otherErrs++;
                    $display("Malformed line in the stimulus file: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic runCase(input int c);
        caseIdx = c;
        extRow = tab[c][0] + 1;
        extBlk = tab[c][1] + 1;
        extFrm = tab[c][2] + 1;
        extPat = tab[c][3] + 1;
        extGrp = tab[c][4] + 1;
        patInner = tab[c][5] != 0;
        maxLat = (tab[c][6] < 1) ? 1 : tab[c][6];
        maxDelay = tab[c][7];
        passWords = extRow * extRow * extBlk * extFrm;
        wordsModel = passWords * extPat * extGrp;
        shapeWord = '0;
        shapeWord.shape.f.lenRow = `ROW_W'(tab[c][0]);
        shapeWord.shape.f.numBlk = `BLK_W'(tab[c][1]);
        shapeWord.shape.f.numFrm = `FRM_W'(tab[c][2]);
        loopWord = '0;
        loopWord.loops.f.numPat = `PAT_W'(tab[c][3]);
        loopWord.loops.f.numFtrGrp = `GRP_W'(tab[c][4]);
        loopWord.loops.f.patchFirst = patInner;
        wordIdx = 0;
        reqIdx = 0;
        npCnt = 0;
        ngCnt = 0;
        busyCycles = 0;
        doneSeen = 1'b0;
        cfgWrEn = 1'b1;
        cfgAddr = CFG_ADDR_SHAPE;
        cfgData = shapeWord;
        stepCycle();
        cfgWrEn = 1'b1;
        cfgAddr = CFG_ADDR_LOOP;
        cfgData = loopWord;
        stepCycle();
        start = 1'b1;
        stepCycle();
        check("busy", busy, 1);
        while (!doneSeen || busy || memQ.size() > 0 || crdQ.size() > 0) begin
            stepCycle();
        end
        check("outValid count", wordIdx, tab[c][8]);
        check("outNextPatch count", npCnt, tab[c][9]);
        check("outNextFtrGrp count", ngCnt, tab[c][10]);
    endtask

    initial begin
        seed = 32'hf6fa_9f81;
        rst_n = 1'b0;
        cfgWrEn = 1'b0;
        cfgAddr = CFG_ADDR_SHAPE;
        cfgData = '0;
        start = 1'b0;
        actValid = 1'b0;
        actData = '0;
        outCredit = 1'b0;
        caseIdx = -1;
        maxLat = 1;
        maxDelay = 0;
        readCases();
        if (numCases == 0) begin
            otherErrs++;
            $display("No test cases were read");
        end
        cycleLimit = 200;
        for (int c = 0; c < numCases; c++) begin
            cycleLimit += tab[c][8] * (tab[c][6] + tab[c][7] + 4);
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        stepCycle();
        check("actReq", actReq, 0);
        check("outValid", outValid, 0);
        check("busy", busy, 0);
        check("layerDone", layerDone, 0);
        for (int c = 0; c < numCases; c++) begin
            runCase(c);
        end
        reportCounts();
        if (valueErrs == 0 && otherErrs == 0 && dut_i.fetch_i.props_i.failCnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/act_ctrl_input.txt */
# lenRow numBlk numFrm numPat numFtrGrp patchFirst maxLat maxDelay words nextPatch nextFtrGrp
# counts stored minus one, latency and delay in cycles, last three are expected totals
2 0 0 0 0 1 1 0 9 0 0
1 1 1 1 1 1 3 2 64 3 1
1 1 1 1 1 0 3 2 64 1 3
3 1 0 2 0 1 5 1 96 2 0
3 1 0 2 0 0 5 1 96 2 0
2 0 2 0 2 0 2 12 81 0 2
4 0 1 1 2 1 4 20 300 5 2
0 3 3 1 1 0 2 3 64 1 3
5 0 0 0 1 1 6 6 72 0 1

/* testbench/act_ctrl_props.sv */
`include "act_config.svh"

module actCtrlProps (
    input logic              clk,
    input logic              rst_n,
    input logic [`CRD_W-1:0] crdCnt,
    input logic              actReq,
    input logic              outCredit,
    input logic              actValid,
    input logic              outValid
);
    timeunit 1ns;
    timeprecision 1ps;

    int                failCnt;     // Failed assertions so far
    logic [`CRD_W-1:0] inFlight;    // Requests not yet paid back by the consumer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inFlight <= '0;
        end else if (actReq && !outCredit) begin
            inFlight <= inFlight + 1'b1;
        end else if (!actReq && outCredit) begin
            inFlight <= inFlight - 1'b1;
        end
    end

    // Credits only come back for words already sent
    crdLimit: assert property (@(posedge clk) disable iff (!rst_n)
        crdCnt <= `ACT_CREDITS)
        else begin
            failCnt++;
            $error("credit count above the slot count");
        end

    reqNeedsCrd: assert property (@(posedge clk) disable iff (!rst_n)
        actReq |-> inFlight < `ACT_CREDITS)
        else begin
            failCnt++;
            $error("request issued with every consumer slot taken");
        end

    // Single register stage on the output
    outFollows: assert property (@(posedge clk) disable iff (!rst_n)
        actValid |=> outValid)
        else begin
            failCnt++;
            $error("returned word did not reach the output");
        end

    noExtraOut: assert property (@(posedge clk) disable iff (!rst_n)
        !actValid |=> !outValid)
        else begin
            failCnt++;
            $error("output word without a memory return");
        end

endmodule

bind actFetchCredit actCtrlProps props_i (
    .clk(clk), .rst_n(rst_n), .crdCnt(crdCnt), .actReq(actReq),
    .outCredit(outCredit), .actValid(actValid), .outValid(outValid)
);
